// File: compile.f
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
stage_reg.sv
decode_unit.sv
reg_file.sv
alu.sv
hazard_unit.sv
rv_pipeline.sv
rv_pipeline_props.sv
tb_rv_pipeline.sv

// File: tb_rv_pipeline.sv
`timescale 1ns/1ns
`include "rv_core_cfg.svh"

module tb_rv_pipeline
    import rv_isa_pkg::*, rv_pipe_pkg::*;
();

    localparam int MEM_WORDS = 1 << `RV_IADDR_SIZE;

    typedef logic [`RV_IADDR_SIZE-1:0] waddr_t;

    typedef struct packed {
        logic     is_store;
        waddr_t   addr;
        reg_idx_t rd;
        data_t    value;
    } event_t;

    logic     CLK;
    logic     RESET_N;
    logic     clear;
    data_t    idata;
    waddr_t   iaddr;
    waddr_t   daddr;
    data_t    ddata_r;
    data_t    ddata_w;
    logic     mem_read;
    logic     mem_write;
    data_t    reg_write_data;
    logic     reg_write_enable;
    reg_idx_t write_register;

    data_t       rom [0:MEM_WORDS-1];
    data_t       ram [0:MEM_WORDS-1];
    data_t       prog [$];
    event_t      exp_q [$];
    string       exp_name [$];
    int          ev_idx = 0;
    int          n_first;
    int          n_loads = 0;
    int          exp_loads = 0;
    logic [15:0] lfsr_state = 16'd57278;

    rv_pipeline DUT (.*);

    assign idata   = rom[iaddr]; // Both memories answer in the same cycle
    assign ddata_r = ram[daddr];

    always @(posedge CLK) begin
        if (mem_write) begin
            ram[daddr] <= ddata_w;
        end
    end

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    task automatic next_imm12(output logic [11:0] imm);
        for (int b = 0; b < 12; b++) begin
            imm = {imm[10:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic data_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic data_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, OP_R};
    endfunction

    function automatic data_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd, input opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic data_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OP_STORE};
    endfunction

    function automatic data_t b_type(input logic [12:0] off, input reg_idx_t rs1,
                                     input reg_idx_t rs2, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic data_t j_type(input logic [20:0] off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    task automatic add_wb(input string name, input reg_idx_t rd, input data_t v);
        exp_q.push_back('{is_store: 1'b0, addr: '0, rd: rd, value: v});
        exp_name.push_back(name);
    endtask

    task automatic add_store(input string name, input waddr_t a, input data_t v);
        exp_q.push_back('{is_store: 1'b1, addr: a, rd: '0, value: v});
        exp_name.push_back(name);
    endtask

    task automatic build_program;
        logic [11:0] imm;
        data_t       rnd [0:3];
        for (int i = 0; i < 4; i++) begin
            next_imm12(imm);
            rnd[i] = sext12(imm);
            prog.push_back(i_type(imm, 0, F3_ADD_SUB, reg_idx_t'(i + 1), OP_IMM));
            add_wb("addi_rand", reg_idx_t'(i + 1), rnd[i]);
        end
        prog.push_back(i_type(12'd100, 0, F3_ADD_SUB, 5, OP_IMM));
        add_wb("rtype_chain", 5, 32'd100);
        prog.push_back(i_type(12'hFF9, 0, F3_ADD_SUB, 6, OP_IMM));
        add_wb("rtype_chain", 6, 32'hFFFF_FFF9);
        prog.push_back(r_type(7'h00, F3_ADD_SUB, 7, 5, 6));
        add_wb("rtype_chain", 7, 32'd93);
        prog.push_back(r_type(7'h20, F3_ADD_SUB, 8, 7, 5));
        add_wb("rtype_chain", 8, 32'hFFFF_FFF9);
        prog.push_back(r_type(7'h00, F3_AND, 9, 8, 7));
        add_wb("rtype_chain", 9, 32'h0000_0059);
        prog.push_back(r_type(7'h00, F3_OR, 10, 9, 6));
        add_wb("rtype_chain", 10, 32'hFFFF_FFF9);
        prog.push_back(r_type(7'h00, F3_XOR, 11, 10, 5));
        add_wb("rtype_chain", 11, 32'hFFFF_FF9D);
        prog.push_back(r_type(7'h00, F3_SLT, 12, 11, 5));
        add_wb("rtype_chain", 12, 32'd1);
        prog.push_back(r_type(7'h00, F3_SLT, 13, 5, 11));
        add_wb("rtype_chain", 13, 32'd0);
        prog.push_back(r_type(7'h00, F3_ADD_SUB, 14, 1, 2));
        add_wb("rtype_chain", 14, rnd[0] + rnd[1]);
        prog.push_back(s_type(12'd8, 11, 5)); // Byte address 108 is word 27
        add_store("store_load", 27, 32'hFFFF_FF9D);
        prog.push_back(i_type(12'd8, 5, F3_WORD, 15, OP_LOAD));
        exp_loads++;
        add_wb("store_load", 15, 32'hFFFF_FF9D);
        prog.push_back(i_type(12'd3, 15, F3_ADD_SUB, 16, OP_IMM));
        add_wb("store_load", 16, 32'hFFFF_FFA0);
        prog.push_back(b_type(13'd12, 5, 5, F3_BEQ)); // Taken
        prog.push_back(i_type(12'd1, 0, F3_ADD_SUB, 20, OP_IMM));
        prog.push_back(i_type(12'd2, 0, F3_ADD_SUB, 21, OP_IMM));
        prog.push_back(b_type(13'd12, 5, 6, F3_BNE)); // Taken
        prog.push_back(i_type(12'd3, 0, F3_ADD_SUB, 20, OP_IMM));
        prog.push_back(i_type(12'd4, 0, F3_ADD_SUB, 21, OP_IMM));
        prog.push_back(b_type(13'd8, 5, 6, F3_BEQ));
        prog.push_back(i_type(12'd5, 0, F3_ADD_SUB, 18, OP_IMM));
        add_wb("branch", 18, 32'd5);
        prog.push_back(b_type(13'd8, 5, 5, F3_BNE));
        prog.push_back(i_type(12'd6, 0, F3_ADD_SUB, 19, OP_IMM));
        add_wb("branch", 19, 32'd6);
        add_wb("jal_lui", 22, data_t'((prog.size() + 1) * 4));
        prog.push_back(j_type(21'd12, 22));
        prog.push_back(i_type(12'd7, 0, F3_ADD_SUB, 20, OP_IMM));
        prog.push_back(i_type(12'd8, 0, F3_ADD_SUB, 21, OP_IMM));
        prog.push_back({20'hABCDE, 5'd23, OP_LUI});
        add_wb("jal_lui", 23, 32'hABCD_E000);
        n_first = exp_q.size();
        prog.push_back(32'h0000_0000);
        // These three are in flight when clear hits and must vanish
        prog.push_back(i_type(12'h155, 0, F3_ADD_SUB, 24, OP_IMM));
        prog.push_back(s_type(12'd0, 0, 0));
        prog.push_back(i_type(12'd9, 0, F3_ADD_SUB, 25, OP_IMM));
        prog.push_back(i_type(12'd1, 23, F3_ADD_SUB, 24, OP_IMM));
        add_wb("after_clear", 24, 32'hABCD_E001);
        prog.push_back(s_type(12'd0, 24, 0));
        add_store("after_clear", 0, 32'hABCD_E001);
        prog.push_back(i_type(12'd0, 0, F3_WORD, 25, OP_LOAD));
        exp_loads++;
        add_wb("after_clear", 25, 32'hABCD_E001);
        prog.push_back(j_type(21'd0, 0)); // Park in a loop
    endtask

    task automatic check_wb(input string name, input reg_idx_t exp_rd, input data_t exp_val,
                            input reg_idx_t act_rd, input data_t act_val);
        if (act_rd !== exp_rd || act_val !== exp_val) begin
            abort_run($sformatf("MISMATCH %s: expected x%0d = %h, actual x%0d = %h",
                                name, exp_rd, exp_val, act_rd, act_val));
        end
    endtask

    task automatic check_store(input string name, input waddr_t exp_addr, input data_t exp_val,
                               input waddr_t act_addr, input data_t act_val);
        if (act_addr !== exp_addr || act_val !== exp_val) begin
            abort_run($sformatf("MISMATCH %s: expected [%0d] = %h, actual [%0d] = %h",
                                name, exp_addr, exp_val, act_addr, act_val));
        end
    endtask

    // Writeback is older than the store in MEM, so it is checked first
    always @(negedge CLK) begin
        if (DUT.u_props.fail_count != 0) begin
            abort_run("An assertion on the pipeline control failed");
        end
        if (RESET_N && mem_read) begin
            n_loads++;
        end
        if (RESET_N && reg_write_enable) begin
            if (ev_idx >= exp_q.size() || exp_q[ev_idx].is_store) begin
                abort_run($sformatf("Unexpected writeback of %h to x%0d after %0d events",
                                    reg_write_data, write_register, ev_idx));
            end else begin
                check_wb(exp_name[ev_idx], exp_q[ev_idx].rd, exp_q[ev_idx].value,
                         write_register, reg_write_data);
                ev_idx++;
            end
        end
        if (RESET_N && mem_write) begin
            if (ev_idx >= exp_q.size() || !exp_q[ev_idx].is_store) begin
                abort_run($sformatf("Unexpected store of %h to word %0d after %0d events",
                                    ddata_w, daddr, ev_idx));
            end else begin
                check_store(exp_name[ev_idx], exp_q[ev_idx].addr, exp_q[ev_idx].value,
                            daddr, ddata_w);
                ev_idx++;
            end
        end
    end

    task automatic wait_events(input int target, input int limit, input string what);
        int cycles;
        cycles = 0;
        while (ev_idx < target) begin
            @(posedge CLK);
            cycles++;
            if (cycles > limit) begin
                abort_run($sformatf("Timeout while waiting for the %s", what));
            end
        end
    endtask

    initial begin
        RESET_N = 1'b0;
        clear   = 1'b0;
        build_program();
        for (int a = 0; a < MEM_WORDS; a++) begin
            rom[a] = '0; // All-zero word decodes as a NOP
            ram[a] <= 32'hD000_0000 | a;
        end
        foreach (prog[k]) begin
            rom[k] = prog[k];
        end
        repeat (16) @(posedge CLK);
        #5 RESET_N = 1'b1;
        wait_events(n_first, 400, "first program");
        #5 clear = 1'b1; // Lands while the victims fill MEM, EX and ID
        @(posedge CLK);
        #5 clear = 1'b0;
        wait_events(exp_q.size(), 200, "second program");
        repeat (10) @(posedge CLK);
        if (n_loads == exp_loads) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            abort_run($sformatf("MISMATCH load_count: expected %0d loads, actual %0d",
                                exp_loads, n_loads));
        end
    end

endmodule

// File: rv_pipeline_props.sv
`timescale 1ns/1ns

module rv_pipeline_props
    import rv_isa_pkg::*, rv_pipe_pkg::*;
(
    input logic     CLK,
    input logic     RESET_N,
    input logic     mem_read,
    input logic     mem_write,
    input logic     reg_write_enable,
    input reg_idx_t write_register,
    input logic     flush,
    input ctrl_t    mem_ctrl
);

    int fail_count = 0; // Number of assertion failures so far

    no_read_and_write: assert property (@(posedge CLK) disable iff (!RESET_N)
        !(mem_read && mem_write))
        else begin
            fail_count++;
            $error("Data memory read and write are high together");
        end

    no_write_to_x0: assert property (@(posedge CLK) disable iff (!RESET_N)
        reg_write_enable |-> write_register != '0)
        else begin
            fail_count++;
            $error("Writeback targets x0");
        end

    quiet_in_reset: assert property (@(posedge CLK)
        !RESET_N |-> !(mem_read || mem_write || reg_write_enable))
        else begin
            fail_count++;
            $error("Control output active during reset");
        end

    // The stage register loads zero on the edge that sees flush
    flush_clears_mem: assert property (@(posedge CLK) disable iff (!RESET_N)
        flush |=> mem_ctrl == '0)
        else begin
            fail_count++;
            $error("EX/MEM control not cleared after a flush");
        end

endmodule

bind rv_pipeline rv_pipeline_props u_props (
    .CLK(CLK), .RESET_N(RESET_N), .mem_read(mem_read), .mem_write(mem_write),
    .reg_write_enable(reg_write_enable), .write_register(write_register),
    .flush(flush), .mem_ctrl(ex_mem_q.ctrl)
);

// File: rv_pipeline.sv
`timescale 1ns/1ns
`include "rv_core_cfg.svh"

module rv_pipeline
    import rv_isa_pkg::*, rv_pipe_pkg::*;
(
    input  logic                      CLK,
    input  logic                      RESET_N,
    input  logic                      clear,
    input  data_t                     idata,
    output logic [`RV_IADDR_SIZE-1:0] iaddr,
    output logic [`RV_IADDR_SIZE-1:0] daddr,
    input  data_t                     ddata_r,
    output data_t                     ddata_w,
    output logic                      mem_read,
    output logic                      mem_write,
    output data_t                     reg_write_data,
    output logic                      reg_write_enable,
    output reg_idx_t                  write_register
);

    data_t    pc;
    data_t    pc_next;
    logic     pc_enable;
    logic     stall;
    logic     flush;
    if_id_t   if_id_d;
    if_id_t   if_id_q;
    id_ex_t   id_ex_d;
    id_ex_t   id_ex_q;
    ex_mem_t  ex_mem_d;
    ex_mem_t  ex_mem_q;
    mem_wb_t  mem_wb_d;
    mem_wb_t  mem_wb_q;
    ctrl_t    id_ctrl;
    data_t    id_imm;
    reg_idx_t id_rs1;
    reg_idx_t id_rs2;
    reg_idx_t id_rd;
    data_t    rdata1;
    data_t    rdata2;
    data_t    alu_b;
    data_t    alu_result;
    logic     alu_zero;
    data_t    wb_data;

    // Fetch. Clear holds the PC so the instruction dropped from IF/ID is fetched again
    assign pc_enable = !clear && (flush || !stall);
    assign pc_next   = flush ? ex_mem_q.target : pc + 32'd4;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else if (pc_enable) begin
            pc <= pc_next;
        end
    end

    assign iaddr   = pc[`RV_IADDR_SIZE+1:2];
    assign if_id_d = '{pc: pc, instr: idata};

    stage_reg #(.payload_t(if_id_t)) u_if_id (
        .CLK(CLK), .RESET_N(RESET_N), .enable(!stall), .flush(flush || clear),
        .d(if_id_d), .q(if_id_q)
    );

    decode_unit u_decode (
        .instr(if_id_q.instr), .ctrl(id_ctrl), .imm(id_imm),
        .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd)
    );

    reg_file u_reg_file (
        .CLK(CLK), .RESET_N(RESET_N), .rs1(id_rs1), .rs2(id_rs2),
        .rd(mem_wb_q.rd), .wdata(wb_data), .we(mem_wb_q.reg_write),
        .rdata1(rdata1), .rdata2(rdata2)
    );

    hazard_unit u_hazard (
        .id_rs1(id_rs1), .id_rs2(id_rs2), .ex_rd(id_ex_q.rd), .mem_rd(ex_mem_q.rd),
        .ex_reg_write(id_ex_q.ctrl.reg_write), .mem_reg_write(ex_mem_q.ctrl.reg_write),
        .mem_ctrl(ex_mem_q.ctrl), .mem_zero(ex_mem_q.zero), .stall(stall), .flush(flush)
    );

    always_comb begin
        id_ex_d.ctrl = stall ? ctrl_t'('0) : id_ctrl; // Bubble while the interlock holds
        id_ex_d.pc   = if_id_q.pc;
        id_ex_d.op1  = rdata1;
        id_ex_d.op2  = rdata2;
        id_ex_d.imm  = id_imm;
        id_ex_d.rd   = id_rd;
        id_ex_d.rs1  = id_rs1;
        id_ex_d.rs2  = id_rs2;
    end

    stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .CLK(CLK), .RESET_N(RESET_N), .enable(1'b1), .flush(flush || clear),
        .d(id_ex_d), .q(id_ex_q)
    );

    // Execute
    assign alu_b = id_ex_q.ctrl.alu_src ? id_ex_q.imm : id_ex_q.op2;

    alu u_alu (
        .a(id_ex_q.op1), .b(alu_b), .op(id_ex_q.ctrl.alu_op),
        .result(alu_result), .zero(alu_zero)
    );

    always_comb begin
        ex_mem_d.ctrl       = id_ex_q.ctrl;
        ex_mem_d.target     = id_ex_q.pc + id_ex_q.imm;
        ex_mem_d.alu_result = alu_result;
        ex_mem_d.zero       = alu_zero;
        ex_mem_d.store_data = id_ex_q.op2;
        ex_mem_d.rd         = id_ex_q.rd;
        ex_mem_d.link       = id_ex_q.pc + 32'd4;
    end

    stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .CLK(CLK), .RESET_N(RESET_N), .enable(1'b1), .flush(flush || clear),
        .d(ex_mem_d), .q(ex_mem_q)
    );

    // Memory stage drives the data bus and resolves branches through the hazard unit
    assign daddr     = ex_mem_q.alu_result[`RV_IADDR_SIZE+1:2];
    assign ddata_w   = ex_mem_q.store_data;
    assign mem_read  = ex_mem_q.ctrl.mem_read;
    assign mem_write = ex_mem_q.ctrl.mem_write;

    always_comb begin
        mem_wb_d.reg_write  = ex_mem_q.ctrl.reg_write;
        mem_wb_d.wb_src     = ex_mem_q.ctrl.wb_src;
        mem_wb_d.alu_result = ex_mem_q.alu_result;
        mem_wb_d.load_data  = ddata_r;
        mem_wb_d.link       = ex_mem_q.link;
        mem_wb_d.rd         = ex_mem_q.rd;
    end

    stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .CLK(CLK), .RESET_N(RESET_N), .enable(1'b1), .flush(clear),
        .d(mem_wb_d), .q(mem_wb_q)
    );

    // Writeback
    always_comb begin
        case (mem_wb_q.wb_src)
            WB_MEM:  wb_data = mem_wb_q.load_data;
            WB_LINK: wb_data = mem_wb_q.link;
            default: wb_data = mem_wb_q.alu_result;
        endcase
    end

    assign reg_write_data   = wb_data;
    assign reg_write_enable = mem_wb_q.reg_write;
    assign write_register   = mem_wb_q.rd;

endmodule

// File: hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit
    import rv_isa_pkg::*, rv_pipe_pkg::*;
(
    input  reg_idx_t id_rs1,
    input  reg_idx_t id_rs2,
    input  reg_idx_t ex_rd,
    input  reg_idx_t mem_rd,
    input  logic     ex_reg_write,
    input  logic     mem_reg_write,
    input  ctrl_t    mem_ctrl,
    input  logic     mem_zero,
    output logic     stall,
    output logic     flush
);

    logic rs1_busy;
    logic rs2_busy;

    // No forwarding, so any pending write in EX or MEM holds decode
    assign rs1_busy = (id_rs1 != '0) &&
                      ((ex_reg_write && id_rs1 == ex_rd) || (mem_reg_write && id_rs1 == mem_rd));
    assign rs2_busy = (id_rs2 != '0) &&
                      ((ex_reg_write && id_rs2 == ex_rd) || (mem_reg_write && id_rs2 == mem_rd));

    assign stall = rs1_busy || rs2_busy;

    assign flush = mem_ctrl.jump || (mem_ctrl.branch && (mem_zero != mem_ctrl.is_bne));

endmodule

// File: alu.sv
`timescale 1ns/1ns

module alu
    import rv_isa_pkg::*;
(
    input  data_t   a,
    input  data_t   b,
    input  alu_op_t op,
    output data_t   result,
    output logic    zero
);

    always_comb begin
        result = '0;
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_SLT:    result[0] = $signed(a) < $signed(b);
            ALU_PASS_B: result = b; // LUI takes the immediate as is
            default:    result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: reg_file.sv
`timescale 1ns/1ns
`include "rv_core_cfg.svh"

module reg_file
    import rv_isa_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET_N,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  data_t    wdata,
    input  logic     we,
    output data_t    rdata1,
    output data_t    rdata2
);

    data_t regs [1:`RV_REG_COUNT-1]; // x0 has no storage

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 1; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // Writeback in the same cycle is passed straight to the read ports
    assign rdata1 = (rs1 == '0) ? '0 : (we && rd == rs1) ? wdata : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : (we && rd == rs2) ? wdata : regs[rs2];

endmodule

// File: decode_unit.sv
`timescale 1ns/1ns

module decode_unit
    import rv_isa_pkg::*, rv_pipe_pkg::*;
(
    input  data_t    instr,
    output ctrl_t    ctrl,
    output data_t    imm,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd
);

    opcode_t  opcode;
    logic [2:0] funct3;
    reg_idx_t f_rs1;
    reg_idx_t f_rs2;
    reg_idx_t f_rd;
    data_t    imm_i;
    data_t    imm_s;
    data_t    imm_b;
    data_t    imm_u;
    data_t    imm_j;
    alu_op_t  r_op;
    logic     r_valid;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign f_rs1  = instr[19:15];
    assign f_rs2  = instr[24:20];
    assign f_rd   = instr[11:7];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // R-type operation from funct3 and bit 30
    always_comb begin
        r_valid = 1'b1;
        r_op    = ALU_ADD;
        case (funct3)
            F3_ADD_SUB: r_op = instr[30] ? ALU_SUB : ALU_ADD;
            F3_SLT:     r_op = ALU_SLT;
            F3_XOR:     r_op = ALU_XOR;
            F3_OR:      r_op = ALU_OR;
            F3_AND:     r_op = ALU_AND;
            default:    r_valid = 1'b0;
        endcase
    end

    always_comb begin
        ctrl = '0;
        imm  = '0;
        rs1  = '0;
        rs2  = '0;
        rd   = '0;
        case (opcode)
            OP_R: begin
                if (r_valid) begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_op    = r_op;
                    rs1 = f_rs1;
                    rs2 = f_rs2;
                    rd  = f_rd;
                end
            end
            OP_IMM: begin
                if (funct3 == F3_ADD_SUB) begin // ADDI only
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_src   = 1'b1;
                    imm = imm_i;
                    rs1 = f_rs1;
                    rd  = f_rd;
                end
            end
            OP_LOAD: begin
                if (funct3 == F3_WORD) begin
                    ctrl.reg_write = 1'b1;
                    ctrl.mem_read  = 1'b1;
                    ctrl.alu_src   = 1'b1;
                    ctrl.wb_src    = WB_MEM;
                    imm = imm_i;
                    rs1 = f_rs1;
                    rd  = f_rd;
                end
            end
            OP_STORE: begin
                if (funct3 == F3_WORD) begin
                    ctrl.mem_write = 1'b1;
                    ctrl.alu_src   = 1'b1;
                    imm = imm_s;
                    rs1 = f_rs1;
                    rs2 = f_rs2;
                end
            end
            OP_BRANCH: begin
                if (funct3 == F3_BEQ || funct3 == F3_BNE) begin
                    ctrl.branch = 1'b1;
                    ctrl.alu_op = ALU_SUB; // Zero flag compares the operands
                    ctrl.is_bne = (funct3 == F3_BNE);
                    imm = imm_b;
                    rs1 = f_rs1;
                    rs2 = f_rs2;
                end
            end
            OP_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_PASS_B;
                imm = imm_u;
                rd  = f_rd;
            end
            OP_JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_src    = WB_LINK;
                imm = imm_j;
                rd  = f_rd;
            end
            default: ;
        endcase
        // A write to x0 is dropped here so it never reaches writeback or the interlock
        if (rd == '0) begin
            ctrl.reg_write = 1'b0;
        end
    end

endmodule

// File: stage_reg.sv
`timescale 1ns/1ns

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     CLK,
    input  logic     RESET_N,
    input  logic     enable,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            q <= '0;
        end else if (flush) begin
            q <= '0; // Flush wins over a held stage
        end else if (enable) begin
            q <= d;
        end
    end

endmodule

// File: rv_pipe_pkg.sv
package rv_pipe_pkg;

    import rv_isa_pkg::*;

    typedef struct packed {
        logic    branch;
        logic    jump;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src; // Second ALU operand is the immediate
        wb_src_t wb_src;
        alu_op_t alu_op;
        logic    is_bne;
    } ctrl_t;

    typedef struct packed {
        data_t pc;
        data_t instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t    ctrl;
        data_t    pc;
        data_t    op1;
        data_t    op2;
        data_t    imm;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } id_ex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        data_t    target;
        data_t    alu_result;
        logic     zero;
        data_t    store_data;
        reg_idx_t rd;
        data_t    link; // Return address for JAL
    } ex_mem_t;

    typedef struct packed {
        logic     reg_write;
        wb_src_t  wb_src;
        data_t    alu_result;
        data_t    load_data;
        data_t    link;
        reg_idx_t rd;
    } mem_wb_t;

endpackage

// File: rv_isa_pkg.sv
`include "rv_core_cfg.svh"

package rv_isa_pkg;

    typedef logic [`RV_DATA_SIZE-1:0] data_t;
    typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_idx_t;

    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_LUI    = 7'b0110111,
        OP_JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0, // Zero value so a cleared bundle adds
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_PASS_B = 4'd6
    } alu_op_t;

    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_MEM  = 2'd1,
        WB_LINK = 2'd2
    } wb_src_t;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010; // Only word loads and stores exist
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

endpackage

// File: rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// Core word width, shared by the register file, ALU and data bus
`define RV_DATA_SIZE 32

`define RV_IADDR_SIZE 10 // Word address width of instruction and data memory

`define RV_REG_COUNT 32 // Architectural registers including x0

`endif
